/* vslc_top.f */
+incdir+src
src/vslc_pkg.sv
src/eeprom_fetch.sv
src/instr_decode.sv
src/stack_execute.sv
src/scan_timer.sv
src/input_sampler.sv
src/vslc_top.sv
verif/eeprom_model.sv
verif/tb_vslc_top.sv

/* Makefile */
# Verilator build for the VSLC testbench
VERILATOR ?= verilator
TOP       ?= tb_vslc_top
FILELIST  ?= vslc_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_vslc_top.sv */
/*
  VSLC testbench
  Loads a program image per test into the EEPROM model, drives sampled
  inputs and checks outputs, stack results and timer periods
*/
`timescale 1ns/1ns

module tb_vslc_top;

  localparam int PERIOD   = 100;
  localparam int SCAN_CYC = 2 + 24 + 8 * 40;  // Upper bound for the images used
  localparam int N_SCANS  = 2 + 13 + 13 + 17 + 3 + 6;
  localparam longint WATCHDOG_NS = 64'd4 * (N_SCANS * SCAN_CYC + 6 * 12) * PERIOD;
  localparam int PA  = 3;
  localparam int PB  = 2;
  localparam int DIV = 1;

  logic       clk;
  logic       rst_n;
  logic [7:0] in_pins;
  logic       cycle_start;
  logic       eeprom_cipo;
  logic [7:0] out_pins;
  logic       tos;
  logic       timer_out;
  logic       eeprom_cs;
  logic       eeprom_copi;

  int          errors;
  int          err_mark;
  int          tests;
  int          failed_tests;
  int          checks;
  int unsigned rng;
  logic [7:0]  prog_q[$];
  int          tog_time[$];
  logic        tog_val[$];
  int          cyc_cnt;
  logic        tout_q;

  vslc_top DUT (
    .clk, .rst_n, .in_pins, .cycle_start, .eeprom_cipo,
    .out_pins, .tos, .timer_out, .eeprom_cs, .eeprom_copi
  );

  eeprom_model EEPROM (
    .clk, .cs(eeprom_cs), .copi(eeprom_copi), .cipo(eeprom_cipo)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

  // Toggle log of timer_out
  always @(negedge clk) begin
    cyc_cnt++;
    if (rst_n && timer_out !== tout_q) begin
      tog_time.push_back(cyc_cnt);
      tog_val.push_back(timer_out);
    end
    tout_q = timer_out;
  end

  // CS must come up the cycle after reset is seen
  cs_on_reset: assert property (@(posedge clk) !rst_n |=> eeprom_cs)
    else begin
      errors++;
      $display("mismatch at %0t: eeprom_cs = %b, expected 1", $time, eeprom_cs);
    end

  function automatic logic [7:0] rand_byte();
    rng = rng * 32'd1103515245 + 32'd12345;
    return rng[23:16];
  endfunction

  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a) ^ 8'(a >> 8) ^ 8'h5A;
  endfunction

  // Truth table bit 3 belongs to both stack bits low
  function automatic logic table_bit(input logic [3:0] tbl, input logic s1, input logic s0);
    return tbl[3 - {s1, s0}];
  endfunction

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
      end
  endtask

  task automatic load_image();
    int a;
    int last;
    last = 3 + prog_q.size();
    for (a = 0; a < 65536; a++) EEPROM.mem[a] = fill_byte(a);
    EEPROM.mem[0] = 8'h04;  // Start address low, high
    EEPROM.mem[1] = 8'h00;
    EEPROM.mem[2] = 8'(last);
    EEPROM.mem[3] = 8'(last >> 8);
    for (a = 0; a < prog_q.size(); a++) EEPROM.mem[4 + a] = prog_q[a];
    EEPROM.txn_count = 0;
  endtask

  task automatic reset_dut();
    @(posedge clk);
    rst_n       <= 1'b0;
    in_pins     <= '0;
    cycle_start <= 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    check_val("eeprom_cs", 16'(eeprom_cs), 16'd1);
    check_val("out_pins", 16'(out_pins), 16'd0);
    check_val("tos", 16'(tos), 16'd0);
    check_val("timer_out", 16'(timer_out), 16'd0);
    @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // Returns on the negedge after CS rises n times
  task automatic wait_scans(input int n);
    int   seen;
    int   cyc;
    logic cs_q;
    seen = 0;
    cyc  = 0;
    cs_q = eeprom_cs;
    while (seen < n && cyc <= n * SCAN_CYC * 2) begin
      @(negedge clk);
      cyc++;
      if (eeprom_cs && !cs_q) seen++;
      cs_q = eeprom_cs;
    end
    assert (seen >= n)
      else begin
        errors++;
        $display("error at %0t: the DUT stopped starting new scans", $time);
      end
  endtask

  task automatic sample_inputs(input logic [7:0] v);
    @(posedge clk);
    in_pins     <= v;
    cycle_start <= 1'b1;
    repeat (2) @(posedge clk);
    cycle_start <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: FAILED with %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic copy_test();
    logic [7:0] v;
    logic [7:0] exp;
    int         i;
    exp = '0;
    for (i = 0; i < 6; i++) begin
      v = rand_byte();
      sample_inputs(v);
      exp[5:0] = v[5:0];
      exp[6]   = exp[6] | v[6];
      exp[7]   = (exp[7] | v[7]) & ~v[6];
      wait_scans(1);
      check_val("out_pins", 16'(out_pins), 16'(exp));
    end
  endtask

  task automatic logic_test();
    logic [7:0] v;
    logic [7:0] exp;
    int         i;
    for (i = 0; i < 6; i++) begin
      v = rand_byte();
      sample_inputs(v);
      exp    = 8'b0100_0000;  // Set-all pop gives 1, clear pop gives 0
      exp[0] = table_bit(4'h1, v[0], v[1]);
      exp[1] = table_bit(4'h6, v[0], v[1]);
      exp[2] = v[3];
      exp[3] = v[2];
      exp[5] = v[4];
      wait_scans(1);
      check_val("out_pins", 16'(out_pins), 16'(exp));
      check_val("tos", 16'(tos), 16'd1);
    end
  endtask

  task automatic edge_test();
    logic [7:0] v;
    logic       cur;
    logic       prev;
    int         i;
    cur  = 1'b0;
    prev = 1'b0;
    for (i = 0; i < 8; i++) begin
      v = rand_byte();
      if (i < 4) v[0] = (i == 0 || i == 1);  // Rise, hold, fall, hold
      sample_inputs(v);
      prev = cur;
      cur  = v[0];
      wait_scans(1);
      check_val("out_pins", 16'(out_pins), 16'({6'b0, !cur && prev, cur && !prev}));
    end
  endtask

  task automatic cyclic_timer_test();
    int i;
    int gap;
    @(posedge clk);
    tog_time.delete();
    tog_val.delete();
    repeat (120) @(negedge clk);
    assert (tog_time.size() >= 5)
      else begin
        errors++;
        $display("error at %0t: timer_out toggled only %0d times", $time, tog_time.size());
      end
    for (i = 1; i < tog_time.size(); i++) begin
      gap = tog_val[i] ? (PA + 1) << DIV : (PB + 1) << DIV;
      check_val("timer_out gap", 16'(tog_time[i] - tog_time[i - 1]), 16'(gap));
    end
  endtask

  task automatic one_shot_test();
    sample_inputs(8'h01);
    tog_time.delete();
    tog_val.delete();
    wait_scans(1);
    sample_inputs(8'h00);
    wait_scans(3);
    check_val("timer_out toggles", 16'(tog_time.size()), 16'd2);
    if (tog_time.size() == 2) begin
      check_val("timer_out gap", 16'(tog_time[1] - tog_time[0]), 16'((PB + 1) << DIV));
    end
    check_val("timer_out", 16'(timer_out), 16'd0);
  endtask

  initial begin
    rst_n        = 1'b0;
    in_pins      = '0;
    cycle_start  = 1'b0;
    errors       = 0;
    err_mark     = 0;
    tests        = 0;
    failed_tests = 0;
    checks       = 0;
    rng          = 99;
    cyc_cnt      = 0;
    tout_q       = 1'b0;

    // Push input, pop output for pins 0..5, then set and reset rules
    prog_q.delete();
    for (int i = 0; i < 6; i++) begin
      prog_q.push_back(8'(i));
      prog_q.push_back(8'h18 | 8'(i));
    end
    prog_q = {prog_q, 8'h06, 8'h2E, 8'h07, 8'h2F, 8'h06, 8'h3F};
    load_image();
    reset_dut();
    wait_scans(1);
    check_val("last_cmd", 16'(EEPROM.last_cmd), 16'h0003);
    check_val("last_addr", EEPROM.last_addr, 16'h0000);
    check_val("txn_count", 16'(EEPROM.txn_count), 16'd1);
    wait_scans(1);
    check_val("last_addr", EEPROM.last_addr, 16'h0004);
    check_val("txn_count", 16'(EEPROM.txn_count), 16'd2);
    finish_test("reset and fetch");
    copy_test();
    finish_test("copy, set and reset");

    prog_q = {8'h00, 8'h01, 8'hA1, 8'h18, 8'h00, 8'h01, 8'hA6, 8'h19,
              8'hF0, 8'h02, 8'h03, 8'h04, 8'hF2, 8'h1A, 8'hF3, 8'h1B, 8'h1C, 8'h1D,
              8'hF1, 8'h1E, 8'hF0, 8'h1F, 8'hF1};
    load_image();
    reset_dut();
    wait_scans(1);
    logic_test();
    finish_test("logic and stack ops");

    prog_q = {8'hE0, 8'h18, 8'hE8, 8'h19};
    load_image();
    reset_dut();
    wait_scans(1);
    edge_test();
    finish_test("rise and fall");

    prog_q = {8'h70, 8'h00, 8'(PA), 8'h71, 8'h00, 8'(PB), 8'h40 | 8'(DIV), 8'h50,
              8'hF1, 8'h10};
    load_image();
    reset_dut();
    wait_scans(1);
    cyclic_timer_test();
    finish_test("cyclic timer");

    prog_q = {8'h70, 8'h00, 8'(PA), 8'h71, 8'h00, 8'(PB), 8'h40 | 8'(DIV), 8'h51,
              8'h00, 8'h20};
    load_image();
    reset_dut();
    wait_scans(1);
    one_shot_test();
    finish_test("one-shot timer");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* verif/eeprom_model.sv */
/*
  SPI EEPROM model
  Answers the READ command from a 64 KB byte array, one bit per clock,
  and records the last command and address it received
*/
`timescale 1ns/1ns

module eeprom_model (
  input  logic clk,
  input  logic cs,
  input  logic copi,
  output logic cipo
);

  logic [7:0]  mem [0:65535];
  logic [7:0]  last_cmd;
  logic [15:0] last_addr;
  int          txn_count;

  logic [23:0] rx_sr;
  int          bit_cnt;
  logic [15:0] rd_addr;
  int          rd_bit;
  logic        reading;  // A READ command was received

  initial begin
    cipo      = 1'b0;
    last_cmd  = '0;
    last_addr = '0;
    txn_count = 0;
    rx_sr     = '0;
    bit_cnt   = 0;
    rd_addr   = '0;
    rd_bit    = 7;
    reading   = 1'b0;
  end

  // Shift in on the falling edge, drive data on the falling edge
  always @(negedge clk) begin
    if (cs) begin
      bit_cnt <= 0;
      reading <= 1'b0;
    end else if (bit_cnt < 24) begin
      rx_sr   <= {rx_sr[22:0], copi};
      bit_cnt <= bit_cnt + 1;
      if (bit_cnt == 23) begin
        last_cmd  <= rx_sr[22:15];
        last_addr <= {rx_sr[14:0], copi};
        txn_count <= txn_count + 1;
        reading   <= (rx_sr[22:15] == 8'h03);
        cipo      <= (rx_sr[22:15] == 8'h03) ? mem[{rx_sr[14:0], copi}][7] : 1'b0;
        rd_addr   <= {rx_sr[14:0], copi};
        rd_bit    <= 6;
      end
    end else begin
      cipo <= reading ? mem[rd_addr][rd_bit] : 1'b0;
      if (rd_bit == 0) begin
        rd_addr <= rd_addr + 16'd1;  // Sequential read runs on
        rd_bit  <= 7;
      end else begin
        rd_bit <= rd_bit - 1;
      end
    end
  end

endmodule

/* src/vslc_top.sv */
/*
  VSLC top level
  Bit-serial logic controller running its program from an SPI EEPROM
*/
`timescale 1ns/1ns

module vslc_top
  import vslc_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  io_vec_t in_pins,
  input  logic    cycle_start,
  input  logic    eeprom_cipo,
  output io_vec_t out_pins,
  output logic    tos,
  output logic    timer_out,
  output logic    eeprom_cs,
  output logic    eeprom_copi
);

  logic       byte_valid;
  pbyte_t     byte_data;
  byte_kind_t byte_kind;
  logic       op_valid;
  op_t        op;
  target_t    target;
  reg_idx_t   reg_idx;
  pbyte_t     op_arg;
  io_vec_t    in_cur;
  io_vec_t    in_prev;
  logic       timer_en;
  logic       timer_done;
  logic       div_load;
  logic       mode_load;
  clk_div_t   setup_val;

  eeprom_fetch u_fetch (
    .clk, .rst_n, .eeprom_cipo, .eeprom_cs, .eeprom_copi,
    .byte_valid, .byte_data, .byte_kind
  );

  instr_decode u_decode (
    .clk, .rst_n, .byte_valid, .byte_data, .byte_kind,
    .op_valid, .op, .target, .reg_idx, .op_arg
  );

  stack_execute u_execute (
    .clk, .rst_n, .op_valid, .op, .target, .reg_idx, .op_arg,
    .in_cur, .in_prev, .timer_done,
    .out_pins, .tos, .timer_en, .div_load, .mode_load, .setup_val
  );

  scan_timer u_timer (
    .clk, .rst_n, .timer_en, .div_load, .mode_load, .setup_val,
    .byte_valid, .byte_kind, .byte_data, .timer_out, .timer_done
  );

  input_sampler u_sampler (
    .clk, .rst_n, .cycle_start, .in_pins, .in_cur, .in_prev
  );

endmodule

/* src/input_sampler.sv */
/*
  Input sampler
  Captures the input pins on each cycle_start rise and keeps the
  previous sample for edge tests
*/
`timescale 1ns/1ns

module input_sampler
  import vslc_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    cycle_start,
  input  io_vec_t in_pins,
  output io_vec_t in_cur,
  output io_vec_t in_prev
);

  logic start_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start_q <= 1'b0;
      in_cur  <= '0;
      in_prev <= '0;
    end else begin
      start_q <= cycle_start;
      if (cycle_start && !start_q) begin
        in_cur  <= in_pins;
        in_prev <= in_cur;  // Old sample moves down
      end
    end
  end

endmodule

/* src/scan_timer.sv */
/*
  Two-phase period timer
  Ticks every 2^div clocks, toggles timer_out at the end of each phase,
  and ends a one-shot run after phase B
*/
`timescale 1ns/1ns
`include "vslc_defs.svh"

module scan_timer
  import vslc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       timer_en,
  input  logic       div_load,
  input  logic       mode_load,
  input  clk_div_t   setup_val,
  input  logic       byte_valid,
  input  byte_kind_t byte_kind,
  input  pbyte_t     byte_data,
  output logic       timer_out,
  output logic       timer_done
);

  localparam int PRE_W = (1 << `VSLC_DIV_W) - 1;
  localparam int HI    = `VSLC_TIMER_W - 1;
  localparam int LO    = `VSLC_BYTE_W;

  clk_div_t         div;
  logic             one_shot;
  timer_val_t       period_a;
  timer_val_t       period_b;
  timer_val_t       count;
  logic [PRE_W-1:0] pre_cnt;
  logic [PRE_W-1:0] div_mask;
  logic             phase;    // 0 is phase A
  logic             stopped;  // Waits for the enable to drop
  logic             tick;

  assign div_mask = ~({PRE_W{1'b1}} << div);
  assign tick     = ((pre_cnt & div_mask) == div_mask) && !stopped;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div      <= '0;
      one_shot <= 1'b0;
      period_a <= timer_val_t'(1);
      period_b <= timer_val_t'(2);
    end else begin
      if (div_load)  div      <= setup_val;
      if (mode_load) one_shot <= setup_val[0];
      if (byte_valid) begin
        case (byte_kind)
          BK_PERIOD_A_HI: period_a[HI:LO]   <= byte_data;
          BK_PERIOD_A_LO: period_a[LO-1:0]  <= byte_data;
          BK_PERIOD_B_HI: period_b[HI:LO]   <= byte_data;
          BK_PERIOD_B_LO: period_b[LO-1:0]  <= byte_data;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || !timer_en) begin  // Disable keeps the setup registers
      pre_cnt    <= '0;
      count      <= '0;
      phase      <= 1'b0;
      timer_out  <= 1'b0;
      stopped    <= 1'b0;
      timer_done <= 1'b0;
    end else begin
      timer_done <= 1'b0;
      if (!stopped) pre_cnt <= pre_cnt + 1'b1;
      if (tick) begin
        if (!phase && count == period_a) begin
          count     <= '0;
          phase     <= 1'b1;
          timer_out <= !timer_out;
        end else if (phase && count == period_b) begin
          count <= '0;
          phase <= 1'b0;
          if (period_b != '0) timer_out <= !timer_out;
          if (one_shot) begin
            timer_done <= 1'b1;
            stopped    <= 1'b1;
          end
        end else begin
          count <= count + 1'b1;
        end
      end
    end
  end

endmodule

/* src/stack_execute.sv */
/*
  Stack execute stage
  Applies one decoded operation per instruction to the bit stack,
  the output latches and the timer enable, and forwards timer setup
*/
`timescale 1ns/1ns
`include "vslc_defs.svh"

module stack_execute
  import vslc_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     op_valid,
  input  op_t      op,
  input  target_t  target,
  input  reg_idx_t reg_idx,
  input  pbyte_t   op_arg,
  input  io_vec_t  in_cur,
  input  io_vec_t  in_prev,
  input  logic     timer_done,
  output io_vec_t  out_pins,
  output logic     tos,
  output logic     timer_en,
  output logic     div_load,
  output logic     mode_load,
  output clk_div_t setup_val
);

  localparam int D = `VSLC_STACK_DEPTH;

  logic [D-1:0] stack;
  logic [D-1:0] stack_nxt;
  io_vec_t      out_nxt;
  logic         ten_nxt;
  logic         lut_bit;
  logic         wr_en;
  logic         wr_val;

  assign lut_bit = op_arg[2'd3 - stack[1:0]];  // Table indexed by the two top bits
  assign wr_en   = (op == OP_POP) || stack[0];
  assign wr_val  = stack[0] && (op != OP_RESET);

  always_comb begin
    stack_nxt = stack;
    out_nxt   = out_pins;
    ten_nxt   = timer_en && !timer_done;  // One-shot run is over
    if (op_valid) begin
      case (op)
        OP_PUSH: stack_nxt = {stack[D-2:0],
                              (target == TGT_OUTPUT) ? out_pins[reg_idx] : in_cur[reg_idx]};
        OP_POP, OP_SET, OP_RESET: begin
          stack_nxt = {stack[D-1], stack[D-1:1]};
          if (wr_en) begin
            if (target == TGT_TIMER) ten_nxt = wr_val;
            else                     out_nxt[reg_idx] = wr_val;
          end
        end
        OP_LOGIC: begin
          case (op_arg[5:4])
            2'd0:    stack_nxt = {stack[D-2:0], lut_bit};             // Push result
            2'd2:    stack_nxt = {stack[D-1], stack[D-1:2], lut_bit}; // Two into one
            default: stack_nxt = {stack[D-1:1], lut_bit};
          endcase
        end
        OP_RISE:   stack_nxt = {stack[D-2:0], in_cur[reg_idx] && !in_prev[reg_idx]};
        OP_FALL:   stack_nxt = {stack[D-2:0], !in_cur[reg_idx] && in_prev[reg_idx]};
        OP_CLR:    stack_nxt = '0;
        OP_SETALL: stack_nxt = '1;
        OP_SWAP:   stack_nxt = {stack[D-1:2], stack[0], stack[1]};
        OP_ROT:    stack_nxt = {stack[D-1:3], stack[0], stack[2], stack[1]};
        default:   stack_nxt = stack;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stack     <= '0;
      out_pins  <= '0;
      tos       <= 1'b0;
      timer_en  <= 1'b0;
      div_load  <= 1'b0;
      mode_load <= 1'b0;
    end else begin
      stack     <= stack_nxt;
      out_pins  <= out_nxt;
      tos       <= stack_nxt[0];
      timer_en  <= ten_nxt;
      div_load  <= op_valid && (op == OP_SET_DIV);
      mode_load <= op_valid && (op == OP_SET_MODE);
    end
  end

  always_ff @(posedge clk) begin
    if (op_valid) setup_val <= op_arg[`VSLC_DIV_W-1:0];
  end

endmodule

/* src/instr_decode.sv */
/*
  Instruction decoder
  Classifies program bytes into an operation, a target and a pin index
*/
`timescale 1ns/1ns
`include "vslc_defs.svh"

module instr_decode
  import vslc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       byte_valid,
  input  pbyte_t     byte_data,
  input  byte_kind_t byte_kind,
  output logic       op_valid,
  output op_t        op,
  output target_t    target,
  output reg_idx_t   reg_idx,
  output pbyte_t     op_arg
);

  op_t     dec_op;
  target_t dec_tgt;

  always_comb begin
    dec_op  = OP_NOP;
    dec_tgt = byte_data[3] ? TGT_OUTPUT : TGT_INPUT;
    case (byte_data[7:6])
      2'b00: begin  // Stack class
        case (byte_data[5:4])
          2'd0:    dec_op = OP_PUSH;
          2'd1:    dec_op = OP_POP;
          2'd2:    dec_op = OP_SET;
          default: dec_op = OP_RESET;
        endcase
        if (byte_data[5:4] != 2'd0 && !byte_data[3]) dec_tgt = TGT_TIMER;
      end
      2'b01: begin  // Setup, 0x7X periods are handled in fetch
        if (byte_data[5:4] == 2'd0)      dec_op = OP_SET_DIV;
        else if (byte_data[5:4] == 2'd1) dec_op = OP_SET_MODE;
      end
      2'b10: dec_op = OP_LOGIC;
      default: begin
        if (byte_data[5:3] == 3'b100)      dec_op = OP_RISE;
        else if (byte_data[5:3] == 3'b101) dec_op = OP_FALL;
        else begin
          case (byte_data)
            `VSLC_OP_CLR:    dec_op = OP_CLR;
            `VSLC_OP_SETALL: dec_op = OP_SETALL;
            `VSLC_OP_SWAP:   dec_op = OP_SWAP;
            `VSLC_OP_ROT:    dec_op = OP_ROT;
            default:         dec_op = OP_NOP;
          endcase
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) op_valid <= 1'b0;
    else        op_valid <= byte_valid && (byte_kind == BK_INSTR);
  end

  always_ff @(posedge clk) begin
    op      <= dec_op;
    target  <= dec_tgt;
    reg_idx <= byte_data[2:0];
    op_arg  <= byte_data;  // Truth table, arity and setup value
  end

endmodule

/* src/eeprom_fetch.sv */
/*
  EEPROM fetch sequencer
  Issues a READ with the scan address, picks up the header when the
  scan starts at 0, then streams program bytes tagged with their kind.
  The first data bit arrives on the falling edge that takes the last
  address bit and is sampled on the next rising edge.
*/
`timescale 1ns/1ns
`include "vslc_defs.svh"

module eeprom_fetch
  import vslc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       eeprom_cipo,
  output logic       eeprom_cs,
  output logic       eeprom_copi,
  output logic       byte_valid,
  output pbyte_t     byte_data,
  output byte_kind_t byte_kind
);

  localparam pbyte_t CMD_READ = `VSLC_CMD_READ;

  fetch_state_t state;
  logic [2:0]   bit_cnt;    // Counts down, wraps to 7 between bytes
  addr_t        cur_addr;   // Address of the byte being read
  addr_t        start_addr;
  addr_t        last_addr;
  logic         period_b;   // Operands go to period B
  logic [6:0]   rx_sr;
  pbyte_t       rx_byte;
  logic         byte_done;

  assign rx_byte   = {rx_sr, eeprom_cipo};
  assign byte_done = (bit_cnt == 3'd0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= CS_HIGH;
      bit_cnt     <= 3'd7;
      cur_addr    <= `VSLC_HDR_ADDR;
      start_addr  <= '0;
      last_addr   <= '0;
      period_b    <= 1'b0;
      eeprom_cs   <= 1'b1;
      eeprom_copi <= 1'b0;
      byte_valid  <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      case (state)
        CS_HIGH: begin
          eeprom_cs <= 1'b1;
          state     <= CS_LOW;
        end
        CS_LOW: begin
          eeprom_cs   <= 1'b0;
          eeprom_copi <= CMD_READ[7];  // First bit goes out with CS
          bit_cnt     <= 3'd6;
          state       <= SEND_CMD;
        end
        SEND_CMD: begin
          eeprom_copi <= CMD_READ[bit_cnt];
          bit_cnt     <= bit_cnt - 3'd1;
          if (byte_done) state <= SEND_ADDR_HI;
        end
        SEND_ADDR_HI: begin
          eeprom_copi <= cur_addr[{1'b1, bit_cnt}];
          bit_cnt     <= bit_cnt - 3'd1;
          if (byte_done) state <= SEND_ADDR_LO;
        end
        SEND_ADDR_LO: begin
          eeprom_copi <= cur_addr[{1'b0, bit_cnt}];
          bit_cnt     <= bit_cnt - 3'd1;
          if (byte_done)
            state <= (cur_addr == `VSLC_HDR_ADDR) ? HDR_START_LO : READ_INSTR;
        end
        default: begin
          bit_cnt <= bit_cnt - 3'd1;
          if (byte_done) begin
            cur_addr <= cur_addr + 1'b1;
            case (state)
              HDR_START_LO: begin
                start_addr[7:0] <= rx_byte;
                state           <= HDR_START_HI;
              end
              HDR_START_HI: begin
                start_addr[15:8] <= rx_byte;
                state            <= HDR_END_LO;
              end
              HDR_END_LO: begin
                last_addr[7:0] <= rx_byte;
                state          <= HDR_END_HI;
              end
              HDR_END_HI: begin
                last_addr[15:8] <= rx_byte;
                state           <= READ_INSTR;
              end
              READ_INSTR: begin
                if (cur_addr > last_addr) begin
                  cur_addr <= start_addr;  // Past the program, rescan
                  state    <= CS_HIGH;
                end else begin
                  byte_valid <= 1'b1;
                  if (rx_byte == `VSLC_OP_PERIOD_A || rx_byte == `VSLC_OP_PERIOD_B) begin
                    period_b <= (rx_byte == `VSLC_OP_PERIOD_B);
                    state    <= READ_OPERAND_HI;
                  end
                end
              end
              READ_OPERAND_HI: begin
                byte_valid <= 1'b1;
                state      <= READ_OPERAND_LO;
              end
              default: begin
                byte_valid <= 1'b1;
                state      <= READ_INSTR;
              end
            endcase
          end
        end
      endcase
    end
  end

  // Receive shifter and byte payload
  always_ff @(posedge clk) begin
    rx_sr <= rx_byte[6:0];
    if (byte_done) begin
      byte_data <= rx_byte;
      case (state)
        READ_OPERAND_HI: byte_kind <= period_b ? BK_PERIOD_B_HI : BK_PERIOD_A_HI;
        READ_OPERAND_LO: byte_kind <= period_b ? BK_PERIOD_B_LO : BK_PERIOD_A_LO;
        default:         byte_kind <= BK_INSTR;
      endcase
    end
  end

endmodule

/* src/vslc_pkg.sv */
/*
  VSLC types
  Vector typedefs and the enums for fetch states, byte kinds,
  decoded operations and operation targets
*/
`include "vslc_defs.svh"

package vslc_pkg;

  typedef logic [`VSLC_ADDR_W-1:0]        addr_t;
  typedef logic [`VSLC_BYTE_W-1:0]        pbyte_t;
  typedef logic [`VSLC_IO_W-1:0]          io_vec_t;
  typedef logic [$clog2(`VSLC_IO_W)-1:0]  reg_idx_t;
  typedef logic [`VSLC_TIMER_W-1:0]       timer_val_t;
  typedef logic [`VSLC_DIV_W-1:0]         clk_div_t;

  typedef enum logic [3:0] {
    CS_HIGH, CS_LOW, SEND_CMD, SEND_ADDR_HI, SEND_ADDR_LO,
    HDR_START_LO, HDR_START_HI, HDR_END_LO, HDR_END_HI,
    READ_INSTR, READ_OPERAND_HI, READ_OPERAND_LO
  } fetch_state_t;

  typedef enum logic [2:0] {
    BK_INSTR, BK_PERIOD_A_HI, BK_PERIOD_A_LO, BK_PERIOD_B_HI, BK_PERIOD_B_LO
  } byte_kind_t;

  typedef enum logic [3:0] {
    OP_NOP, OP_PUSH, OP_POP, OP_SET, OP_RESET, OP_LOGIC, OP_RISE, OP_FALL,
    OP_CLR, OP_SETALL, OP_SWAP, OP_ROT, OP_SET_DIV, OP_SET_MODE
  } op_t;

  typedef enum logic [1:0] {
    TGT_INPUT, TGT_OUTPUT, TGT_TIMER
  } target_t;

endpackage

/* src/vslc_defs.svh */
/*
  VSLC shared constants
  Widths of addresses, program bytes, pins and timer fields,
  plus the EEPROM command and the fixed opcodes
*/
`ifndef VSLC_DEFS_SVH
`define VSLC_DEFS_SVH

`define VSLC_ADDR_W        16
`define VSLC_BYTE_W        8
`define VSLC_IO_W          8
`define VSLC_STACK_DEPTH   16
`define VSLC_TIMER_W       16
`define VSLC_DIV_W         4

// Serial EEPROM read command
`define VSLC_CMD_READ      8'h03

// Header lives at the bottom of the EEPROM
`define VSLC_HDR_ADDR      16'h0000

// Three-byte period instructions
`define VSLC_OP_PERIOD_A   8'h70
`define VSLC_OP_PERIOD_B   8'h71

// Whole-stack operations
`define VSLC_OP_CLR        8'hF0
`define VSLC_OP_SETALL     8'hF1
`define VSLC_OP_SWAP       8'hF2
`define VSLC_OP_ROT        8'hF3

`endif
